// File: src/exec_pkg.sv
package exec_pkg;

	////////////////////////////////////////////////////////////
	// ISA widths and basic types
	////////////////////////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [6:0]            opcode_t;
	typedef logic [2:0]            funct3_t;
	typedef logic [6:0]            funct7_t;

	localparam word_t PC_INC = 32'd4;     // Link offset for JAL/JALR

	// Major opcodes
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;

	// ALU funct3
	localparam funct3_t FN3_ADD_SUB = 3'b000;
	localparam funct3_t FN3_SLL     = 3'b001;
	localparam funct3_t FN3_SLT     = 3'b010;
	localparam funct3_t FN3_SLTU    = 3'b011;
	localparam funct3_t FN3_XOR     = 3'b100;
	localparam funct3_t FN3_SRL_SRA = 3'b101;
	localparam funct3_t FN3_OR      = 3'b110;
	localparam funct3_t FN3_AND     = 3'b111;

	// Branch funct3
	localparam funct3_t FN3_BEQ  = 3'b000;
	localparam funct3_t FN3_BNE  = 3'b001;
	localparam funct3_t FN3_BLT  = 3'b100;
	localparam funct3_t FN3_BGE  = 3'b101;
	localparam funct3_t FN3_BLTU = 3'b110;
	localparam funct3_t FN3_BGEU = 3'b111;

	// Store funct3
	localparam funct3_t FN3_SB = 3'b000;
	localparam funct3_t FN3_SH = 3'b001;
	localparam funct3_t FN3_SW = 3'b010;

	localparam funct7_t FN7_BASE = 7'b0000000;
	localparam funct7_t FN7_ALT  = 7'b0100000;   // SUB / SRA

	typedef enum logic [3:0] {
		CLS_NONE   = 4'd0,
		CLS_REG    = 4'd1,
		CLS_IMM    = 4'd2,
		CLS_LUI    = 4'd3,
		CLS_AUIPC  = 4'd4,
		CLS_BRANCH = 4'd5,
		CLS_JAL    = 4'd6,
		CLS_JALR   = 4'd7,
		CLS_LOAD   = 4'd8,
		CLS_STORE  = 4'd9
	} op_class_t;

endpackage

// File: src/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
	import exec_pkg::*;
(
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  word_t     rs1_data,     // From register file
	input  word_t     rs2_data,
	input  reg_addr_t res_rd_addr,  // Previous result, registered
	input  word_t     res_rd_data,
	input  logic      reg_wr_en,
	output word_t     rs1_val,
	output word_t     rs2_val
);

	logic prev_valid;
	logic fwd_rs1;
	logic fwd_rs2;

	// Only a written, non-x0 destination is worth forwarding
	assign prev_valid = reg_wr_en && (res_rd_addr != '0);

	assign fwd_rs1 = prev_valid && (res_rd_addr == rs1_addr);
	assign fwd_rs2 = prev_valid && (res_rd_addr == rs2_addr);

	assign rs1_val = fwd_rs1 ? res_rd_data : rs1_data;
	assign rs2_val = fwd_rs2 ? res_rd_data : rs2_data;

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu
	import exec_pkg::*;
(
	input  op_class_t op_class,
	input  funct3_t   funct3,
	input  funct7_t   funct7,
	input  word_t     rs1_val,
	input  word_t     rs2_val,
	input  word_t     imm_i,
	output word_t     result
);

	word_t      op_b;
	logic [4:0] shamt;
	logic       is_reg;
	logic       fn7_base;
	logic       fn7_alt;
	logic       plain_ok;

	assign is_reg   = (op_class == CLS_REG);
	assign op_b     = (op_class == CLS_IMM) ? imm_i : rs2_val;
	assign shamt    = op_b[4:0];        // Only the low five bits shift
	assign fn7_base = (funct7 == FN7_BASE);
	assign fn7_alt  = (funct7 == FN7_ALT);

	// Immediate forms ignore funct7 outside the shifts
	assign plain_ok = !is_reg || fn7_base;

	always_comb
	begin
		result = '0;                    // Illegal funct7 leaves zero
		case (funct3)
			FN3_ADD_SUB:
			begin
				if (is_reg && fn7_alt)
					result = rs1_val - op_b;
				else if (plain_ok)
					result = rs1_val + op_b;
			end
			FN3_SLL:
			begin
				if (fn7_base)
					result = rs1_val << shamt;
			end
			FN3_SLT:
			begin
				if (plain_ok)
					result = {{(XLEN-1){1'b0}}, ($signed(rs1_val) < $signed(op_b))};
			end
			FN3_SLTU:
			begin
				if (plain_ok)
					result = {{(XLEN-1){1'b0}}, (rs1_val < op_b)};
			end
			FN3_SRL_SRA:
			begin
				if (fn7_alt)
					result = word_t'($signed(rs1_val) >>> shamt);
				else if (fn7_base)
					result = rs1_val >> shamt;
			end
			FN3_XOR: if (plain_ok) result = rs1_val ^ op_b;
			FN3_OR:  if (plain_ok) result = rs1_val | op_b;
			FN3_AND: if (plain_ok) result = rs1_val & op_b;
			default: result = '0;
		endcase
	end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
	import exec_pkg::*;
(
	input  op_class_t op_class,
	input  funct3_t   funct3,
	input  word_t     pc,
	input  word_t     rs1_val,
	input  word_t     rs2_val,
	input  word_t     imm_b,
	input  word_t     imm_i,
	input  word_t     imm_j,
	output logic      taken,
	output word_t     target
);

	logic cond;
	logic lt_s;
	logic lt_u;

	assign lt_s = $signed(rs1_val) < $signed(rs2_val);
	assign lt_u = rs1_val < rs2_val;

	// Conditional branch outcome
	always_comb
	begin
		case (funct3)
			FN3_BEQ:  cond = (rs1_val == rs2_val);
			FN3_BNE:  cond = (rs1_val != rs2_val);
			FN3_BLT:  cond = lt_s;
			FN3_BGE:  cond = !lt_s;           // Greater or equal
			FN3_BLTU: cond = lt_u;
			FN3_BGEU: cond = !lt_u;
			default:  cond = 1'b0;
		endcase
	end

	always_comb
	begin
		taken  = 1'b0;
		target = '0;
		case (op_class)
			CLS_BRANCH:
			begin
				taken = cond;
				if (cond)
					target = pc + imm_b;
			end
			CLS_JAL:
			begin
				taken  = 1'b1;
				target = pc + imm_j;
			end
			CLS_JALR:
			begin
				taken  = 1'b1;
				target = (rs1_val + imm_i) & ~word_t'(1);   // Clear bit 0
			end
			default:
			begin
				taken  = 1'b0;
				target = '0;
			end
		endcase
	end

endmodule

// File: src/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      halt,
	input  opcode_t   opcode,
	input  logic      taken,        // From branch_unit
	output op_class_t op_class,
	output logic      reg_wr_en,
	output logic      mem_rd_en,
	output logic      mem_wr_en,
	output logic      branch_en
);

	logic writes_rd;

	////////////////////////////////////////////////////////////
	// Opcode decode, the only one in the stage
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			OPC_OP:     op_class = CLS_REG;
			OPC_OP_IMM: op_class = CLS_IMM;
			OPC_LUI:    op_class = CLS_LUI;
			OPC_AUIPC:  op_class = CLS_AUIPC;
			OPC_BRANCH: op_class = CLS_BRANCH;
			OPC_JAL:    op_class = CLS_JAL;
			OPC_JALR:   op_class = CLS_JALR;
			OPC_LOAD:   op_class = CLS_LOAD;
			OPC_STORE:  op_class = CLS_STORE;
			default:    op_class = CLS_NONE;   // Unknown opcode, no enables
		endcase
	end

	// Classes that produce a value for rd
	assign writes_rd = (op_class == CLS_REG)   || (op_class == CLS_IMM)  ||
	                   (op_class == CLS_LUI)   || (op_class == CLS_AUIPC) ||
	                   (op_class == CLS_JAL)   || (op_class == CLS_JALR);

	////////////////////////////////////////////////////////////
	// Registered enables
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || halt)             // Halt drops every enable
		begin
			reg_wr_en <= 1'b0;
			mem_rd_en <= 1'b0;
			mem_wr_en <= 1'b0;
			branch_en <= 1'b0;
		end
		else
		begin
			reg_wr_en <= writes_rd;
			mem_rd_en <= (op_class == CLS_LOAD);
			mem_wr_en <= (op_class == CLS_STORE);
			branch_en <= taken;             // Taken branch or any jump
		end
	end

endmodule

// File: src/exec_datapath.sv
`timescale 1ns/1ps

module exec_datapath
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      halt,
	input  op_class_t op_class,
	input  funct3_t   funct3,
	input  funct7_t   funct7,
	input  reg_addr_t rd_addr,
	input  word_t     pc,
	input  word_t     rs1_val,
	input  word_t     rs2_val,
	input  word_t     imm_i,
	input  word_t     imm_s,
	input  word_t     imm_u,
	input  word_t     target,       // From branch_unit
	output word_t     res_rd_data,
	output reg_addr_t res_rd_addr,
	output funct3_t   res_funct3,
	output word_t     branch_addr,
	output word_t     mem_addr,
	output word_t     mem_data
);

	word_t alu_result;
	word_t rd_data_nxt;
	word_t mem_addr_nxt;
	word_t mem_data_nxt;

	alu u_alu (
		.op_class (op_class),
		.funct3   (funct3),
		.funct7   (funct7),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.imm_i    (imm_i),
		.result   (alu_result)
	);

	////////////////////////////////////////////////////////////
	// Next-state values per class
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op_class)
			CLS_REG, CLS_IMM:   rd_data_nxt = alu_result;
			CLS_LUI:            rd_data_nxt = imm_u;
			CLS_AUIPC:          rd_data_nxt = pc + imm_u;
			CLS_JAL, CLS_JALR:  rd_data_nxt = pc + PC_INC;   // Link address
			default:            rd_data_nxt = '0;
		endcase
	end

	always_comb
	begin
		case (op_class)
			CLS_LOAD:  mem_addr_nxt = rs1_val + imm_i;
			CLS_STORE: mem_addr_nxt = rs1_val + imm_s;
			default:   mem_addr_nxt = '0;
		endcase
	end

	// Store data, zero-extended to the access size
	always_comb
	begin
		mem_data_nxt = '0;
		if (op_class == CLS_STORE)
		begin
			case (funct3)
				FN3_SB:  mem_data_nxt = {24'd0, rs2_val[7:0]};
				FN3_SH:  mem_data_nxt = {16'd0, rs2_val[15:0]};
				FN3_SW:  mem_data_nxt = rs2_val;
				default: mem_data_nxt = '0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Result registers, frozen while halted
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			res_rd_data <= '0;
			res_rd_addr <= '0;
			res_funct3  <= '0;
			branch_addr <= '0;
			mem_addr    <= '0;
			mem_data    <= '0;
		end
		else if (!halt)
		begin
			res_rd_data <= rd_data_nxt;
			res_rd_addr <= rd_addr;
			res_funct3  <= funct3;
			branch_addr <= target;          // Zero unless taken
			mem_addr    <= mem_addr_nxt;
			mem_data    <= mem_data_nxt;
		end
	end

endmodule

// File: src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      halt,
	// Decoded instruction
	input  word_t     pc,
	input  opcode_t   opcode,
	input  funct3_t   funct3,
	input  funct7_t   funct7,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  reg_addr_t rd_addr,
	// Operands and immediates
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	input  word_t     imm_i,
	input  word_t     imm_s,
	input  word_t     imm_b,
	input  word_t     imm_u,
	input  word_t     imm_j,
	// Registered results
	output word_t     res_rd_data,
	output reg_addr_t res_rd_addr,
	output funct3_t   res_funct3,
	output word_t     branch_addr,
	output word_t     mem_addr,
	output word_t     mem_data,
	output logic      reg_wr_en,
	output logic      mem_rd_en,
	output logic      mem_wr_en,
	output logic      branch_en
);

	op_class_t op_class;
	word_t     rs1_val;
	word_t     rs2_val;
	logic      taken;
	word_t     target;

	// Previous result fed back for forwarding
	operand_forward u_operand_forward (
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.res_rd_addr (res_rd_addr),
		.res_rd_data (res_rd_data),
		.reg_wr_en   (reg_wr_en),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val)
	);

	branch_unit u_branch_unit (
		.op_class (op_class),
		.funct3   (funct3),
		.pc       (pc),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.imm_b    (imm_b),
		.imm_i    (imm_i),
		.imm_j    (imm_j),
		.taken    (taken),
		.target   (target)
	);

	exec_ctrl u_exec_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.halt      (halt),
		.opcode    (opcode),
		.taken     (taken),
		.op_class  (op_class),
		.reg_wr_en (reg_wr_en),
		.mem_rd_en (mem_rd_en),
		.mem_wr_en (mem_wr_en),
		.branch_en (branch_en)
	);

	exec_datapath u_exec_datapath (
		.clk         (clk),
		.rst_n       (rst_n),
		.halt        (halt),
		.op_class    (op_class),
		.funct3      (funct3),
		.funct7      (funct7),
		.rd_addr     (rd_addr),
		.pc          (pc),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.imm_i       (imm_i),
		.imm_s       (imm_s),
		.imm_u       (imm_u),
		.target      (target),
		.res_rd_data (res_rd_data),
		.res_rd_addr (res_rd_addr),
		.res_funct3  (res_funct3),
		.branch_addr (branch_addr),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data)
	);

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;         // 20 ns period
	end

	// Reset held over the first two rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: tb/exec_stage_properties.sv
`timescale 1ns/1ps

module exec_stage_properties
	import exec_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      halt,
	input logic      reg_wr_en,
	input logic      mem_rd_en,
	input logic      mem_wr_en,
	input logic      branch_en,
	input word_t     res_rd_data,
	input reg_addr_t res_rd_addr,
	input funct3_t   res_funct3,
	input word_t     branch_addr,
	input word_t     mem_addr,
	input word_t     mem_data
);

	// A result goes to one place only
	enables_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({mem_rd_en, mem_wr_en, reg_wr_en}))
		else $error("more than one of reg_wr_en, mem_rd_en, mem_wr_en high");

	halt_clears_enables: assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> !reg_wr_en && !mem_rd_en && !mem_wr_en && !branch_en)
		else $error("enable still high one cycle after halt");

	halt_holds_data: assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> $stable(res_rd_data) && $stable(res_rd_addr) && $stable(res_funct3) &&
			$stable(branch_addr) && $stable(mem_addr) && $stable(mem_data))
		else $error("data output changed while halted");

endmodule

// File: tb/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage
	import exec_pkg::*;
;

	logic clk, rst_n, halt;
	word_t pc, rs1_data, rs2_data, imm_i, imm_s, imm_b, imm_u, imm_j;
	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	reg_addr_t rs1_addr, rs2_addr, rd_addr, res_rd_addr;
	word_t res_rd_data, branch_addr, mem_addr, mem_data;
	funct3_t res_funct3;
	logic reg_wr_en, mem_rd_en, mem_wr_en, branch_en;
	int n_checks = 0;
	int n_errors = 0;

	tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

	exec_stage u_dut (.*);

	bind exec_stage exec_stage_properties u_props (
		.clk(clk), .rst_n(rst_n), .halt(halt), .reg_wr_en(reg_wr_en),
		.mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en), .branch_en(branch_en),
		.res_rd_data(res_rd_data), .res_rd_addr(res_rd_addr), .res_funct3(res_funct3),
		.branch_addr(branch_addr), .mem_addr(mem_addr), .mem_data(mem_data)
	);

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAIL %0t: %s got %08h expected %08h", $time, msg, got, exp);
		end
	endtask

	task automatic check_enables(input logic rw, input logic mr, input logic mw, input logic be);
		check_eq(32'(reg_wr_en), 32'(rw), "reg_wr_en");
		check_eq(32'(mem_rd_en), 32'(mr), "mem_rd_en");
		check_eq(32'(mem_wr_en), 32'(mw), "mem_wr_en");
		check_eq(32'(branch_en), 32'(be), "branch_en");
	endtask

	// Drive at the falling edge, outputs settle by the next one
	task automatic issue(input opcode_t opc, input funct3_t f3, input funct7_t f7,
		input reg_addr_t rd);
		opcode  = opc;
		funct3  = f3;
		funct7  = f7;
		rd_addr = rd;
		@(negedge clk);
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s done, %0d errors", name, n_errors - err_before);
	endtask

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////

	function automatic word_t alu_model(input logic is_reg, input funct3_t f3, input funct7_t f7,
		input word_t a, input word_t b);
		logic legal;
		logic alt;
		logic [4:0] sh;
		alt = (f7 == 7'h20);
		sh  = b[4:0];
		if (f3 == 3'd1)
			legal = (f7 == 7'h00);
		else if (f3 == 3'd5 || (is_reg && f3 == 3'd0))
			legal = (f7 == 7'h00) || alt;
		else
			legal = !is_reg || (f7 == 7'h00);
		if (!legal)
			return '0;
		case (f3)
			3'd0: return (is_reg && alt) ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> sh) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input funct3_t f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset;
		int e0;
		int cnt;
		e0 = n_errors;
		@(negedge clk);                 // One reset edge has passed
		check_enables(0, 0, 0, 0);
		check_eq(res_rd_data | branch_addr | mem_addr | mem_data, 0, "data in reset");
		check_eq(32'(res_rd_addr), 0, "rd addr in reset");
		check_eq(32'(res_funct3), 0, "funct3 in reset");
		cnt = 0;
		while (rst_n !== 1'b1 && cnt < 10)
		begin
			@(posedge clk);
			cnt++;
		end
		if (rst_n !== 1'b1)
		begin
			n_errors++;
			$display("Reset was never released");
		end
		else
		begin
			@(negedge clk);
			check_enables(0, 0, 0, 0);
			check_eq(res_rd_data | branch_addr | mem_addr | mem_data, 0, "data after reset");
			check_eq(32'(res_rd_addr), 0, "rd addr after reset");
			check_eq(32'(res_funct3), 0, "funct3 after reset");
		end
		report_test("reset", e0);
	endtask

	task automatic test_alu;
		int e0;
		reg_addr_t rd;
		funct7_t f7;
		logic is_reg;
		e0 = n_errors;
		for (int c = 0; c < 2; c++)
			for (int f = 0; f < 8; f++)
				for (int v = 0; v < 3; v++)
				begin
					is_reg   = (c == 0);
					f7       = (v == 0) ? 7'h00 : (v == 1) ? 7'h20 : 7'h01;
					rd       = 5'(4 + ($urandom % 28));
					rs1_data = $urandom;
					rs2_data = $urandom;
					imm_i    = $urandom;
					issue(is_reg ? OPC_OP : OPC_OP_IMM, 3'(f), f7, rd);
					check_eq(res_rd_data, alu_model(is_reg, 3'(f), f7, rs1_data,
						is_reg ? rs2_data : imm_i), "alu result");
					check_eq(32'(res_rd_addr), 32'(rd), "rd echo");
					check_eq(32'(res_funct3), 32'(f), "funct3 echo");
					check_enables(1, 0, 0, 0);
				end
		report_test("alu", e0);
	endtask

	task automatic test_upper_jump;
		int e0;
		e0 = n_errors;
		pc = $urandom & ~32'd3;
		imm_u = $urandom & 32'hFFFF_F000;
		imm_j = 32'h0000_0800;
		rs1_data = 32'h1000_0000;
		imm_i = 32'h0000_0105;          // Odd sum for JALR
		issue(OPC_LUI, 3'd0, 7'd0, 5'd10);
		check_eq(res_rd_data, imm_u, "lui");
		check_enables(1, 0, 0, 0);
		issue(OPC_AUIPC, 3'd0, 7'd0, 5'd10);
		check_eq(res_rd_data, pc + imm_u, "auipc");
		issue(OPC_JAL, 3'd0, 7'd0, 5'd1);
		check_eq(res_rd_data, pc + 32'd4, "jal link");
		check_eq(branch_addr, pc + imm_j, "jal target");
		check_enables(1, 0, 0, 1);
		issue(OPC_JALR, 3'd0, 7'd0, 5'd1);
		check_eq(res_rd_data, pc + 32'd4, "jalr link");
		check_eq(branch_addr, 32'h1000_0104, "jalr target");
		check_enables(1, 0, 0, 1);
		report_test("upper_jump", e0);
	endtask

	task automatic test_branch;
		int e0;
		funct3_t f3s[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		word_t as[3] = '{32'h0000_1234, 32'hFFFF_FFF0, 32'h0000_0010};
		word_t bs[3] = '{32'h0000_1234, 32'h0000_0010, 32'hFFFF_FFF0};
		logic tk;
		e0 = n_errors;
		for (int i = 0; i < 6; i++)
			for (int k = 0; k < 3; k++)
			begin
				pc       = $urandom & ~32'd3;
				imm_b    = 32'hFFFF_FF80;
				rs1_data = as[k];
				rs2_data = bs[k];
				tk       = branch_model(f3s[i], as[k], bs[k]);
				issue(OPC_BRANCH, f3s[i], 7'd0, 5'd0);
				check_enables(0, 0, 0, tk);
				check_eq(branch_addr, tk ? pc + imm_b : 32'd0, "branch target");
			end
		report_test("branch", e0);
	endtask

	task automatic test_mem;
		int e0;
		word_t masks[3] = '{32'h0000_00FF, 32'h0000_FFFF, 32'hFFFF_FFFF};
		e0 = n_errors;
		rs1_data = $urandom;
		rs2_data = $urandom;
		imm_i = $urandom;
		imm_s = $urandom;
		issue(OPC_LOAD, 3'd2, 7'd0, 5'd12);
		check_eq(mem_addr, rs1_data + imm_i, "load address");
		check_eq(mem_data, 0, "load data");
		check_enables(0, 1, 0, 0);
		for (int f = 0; f < 3; f++)
		begin
			issue(OPC_STORE, 3'(f), 7'd0, 5'd0);
			check_eq(mem_addr, rs1_data + imm_s, "store address");
			check_eq(mem_data, rs2_data & masks[f], "store data");
			check_enables(0, 0, 1, 0);
		end
		report_test("mem", e0);
	endtask

	task automatic test_forward_halt;
		int e0;
		word_t r, held_data, held_addr;
		e0 = n_errors;
		rs1_data = $urandom;
		rs2_data = $urandom;
		imm_i = $urandom;
		issue(OPC_OP_IMM, 3'd0, 7'd0, 5'd5);
		r = rs1_data + imm_i;
		check_eq(res_rd_data, r, "producer");
		rs1_addr = 5'd5;
		rs1_data = 32'hDEAD_BEEF;       // Stale register-file value
		issue(OPC_OP, 3'd0, 7'd0, 5'd6);
		check_eq(res_rd_data, r + rs2_data, "forwarded rs1");
		rs1_addr = 5'd2;
		rs1_data = 32'h0000_7777;
		issue(OPC_OP_IMM, 3'd0, 7'd0, 5'd0);   // Write to x0
		rs1_addr = 5'd0;
		rs1_data = 32'd0;
		imm_i = 32'h0000_0321;
		issue(OPC_OP_IMM, 3'd0, 7'd0, 5'd7);
		check_eq(res_rd_data, 32'h0000_0321, "x0 not forwarded");
		held_data = res_rd_data;
		held_addr = 32'(res_rd_addr);
		rs1_addr = 5'd2;
		rs1_data = $urandom;
		halt = 1'b1;
		issue(OPC_OP, 3'd0, 7'd0, 5'd9);
		check_eq(res_rd_data, held_data, "halt holds data");
		check_eq(32'(res_rd_addr), held_addr, "halt holds rd");
		check_enables(0, 0, 0, 0);
		halt = 1'b0;
		rs1_addr = 5'd7;                // Held rd, write enable already low
		issue(OPC_OP, 3'd0, 7'd0, 5'd8);
		check_eq(res_rd_data, rs1_data + rs2_data, "after halt");
		check_enables(1, 0, 0, 0);
		report_test("forward_halt", e0);
	endtask

	initial
	begin
		halt = 1'b0;
		pc = '0;
		opcode = '0;
		funct3 = '0;
		funct7 = '0;
		rs1_addr = 5'd2;
		rs2_addr = 5'd3;
		rd_addr = '0;
		{rs1_data, rs2_data, imm_i, imm_s, imm_b, imm_u, imm_j} = '0;
		void'($urandom(32'ha1ac60fc));
		test_reset();
		test_alu();
		test_upper_jump();
		test_branch();
		test_mem();
		test_forward_halt();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog for a stuck run
	initial
	begin
		#200us;
		$display("Timeout, the run did not finish");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sources.f
src/exec_pkg.sv
src/operand_forward.sv
src/alu.sv
src/branch_unit.sv
src/exec_ctrl.sv
src/exec_datapath.sv
src/exec_stage.sv
tb/tb_clock_gen.sv
tb/exec_stage_properties.sv
tb/tb_exec_stage.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_exec_stage -o sim_exec_stage
	./obj_dir/sim_exec_stage | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
